// File: bus_pkg.sv
/* CPU and PPU bus structs, memory request struct
   and the base addresses of the ROM regions */
package bus_pkg;

	localparam int MEM_ADDR_W = 22; // 4 MiB external memory space

	// Region bases, ORed over the page and offset bits
	localparam logic [MEM_ADDR_W-1:0] PRG_ROM_BASE = 22'h000000; // PRG at bottom
	localparam logic [MEM_ADDR_W-1:0] CHR_ROM_BASE = 22'h200000; // Bits 21:20 = 10

	// CPU side of the cart edge
	typedef struct packed {
		logic [15:0] addr;  // CPU address
		logic [7:0]  data;  // Write data
		logic        write; // Write cycle
		logic        ce;    // M2 enable
	} cpu_bus_t;

	// PPU side of the cart edge
	typedef struct packed {
		logic [13:0] addr; // PPU address
	} ppu_bus_t;

	// Request toward the memory controller
	typedef struct packed {
		logic [MEM_ADDR_W-1:0] prg_addr;
		logic                  prg_allow; // PRG access permitted
		logic [MEM_ADDR_W-1:0] chr_addr;
		logic                  chr_allow; // CHR write permitted
		logic                  vram_a10;  // CIRAM A10
		logic                  vram_ce;   // Route to internal 2 KiB VRAM
	} mem_req_t;

endpackage

// File: cart_checker.sv
/* Memory request checker comparing the DUT request with the
   expected request on each probe cycle, plus the pass and fail counts */
`timescale 1ns/100ps

module cart_checker (
	input  logic              clk,
	input  logic              check_en, // High during a probe cycle
	input  int                test_idx,
	input  bus_pkg::mem_req_t req,      // DUT output
	input  bus_pkg::mem_req_t exp_req,  // Expected request
	output int                pass_cnt,
	output int                fail_cnt
);

	import bus_pkg::*;

	// Names of the fields that disagree
	function automatic string diff_fields(input mem_req_t got, input mem_req_t want);
		string s;
		s = "";
		if (got.prg_addr !== want.prg_addr) begin
			s = {s, " prg_addr"};
		end
		if (got.prg_allow !== want.prg_allow) begin
			s = {s, " prg_allow"};
		end
		if (got.chr_addr !== want.chr_addr) begin
			s = {s, " chr_addr"};
		end
		if (got.chr_allow !== want.chr_allow) begin
			s = {s, " chr_allow"};
		end
		if (got.vram_a10 !== want.vram_a10) begin
			s = {s, " vram_a10"};
		end
		if (got.vram_ce !== want.vram_ce) begin
			s = {s, " vram_ce"};
		end
		return s;
	endfunction

	initial begin
		pass_cnt = 0;
		fail_cnt = 0;
	end

	// Mid-cycle sample of each probe
	always @(negedge clk) begin
		if (check_en) begin
			if (req === exp_req) begin
				pass_cnt = pass_cnt + 1;
				$display("test %0d ok: prg %06h chr %06h a10 %b ce %b", test_idx,
					req.prg_addr, req.chr_addr, req.vram_a10, req.vram_ce);
			end else begin
				fail_cnt = fail_cnt + 1;
				$display("[ERROR] %0d ns: test %0d mismatch in%s, req %012h expected %012h",
					$time, test_idx, diff_fields(req, exp_req), req, exp_req);
			end
		end
	end

endmodule

// File: cart_mapper.f
cart_pkg.sv
bus_pkg.sv
prg_bank_regs.sv
chr_bank_regs.sv
mem_addr_composer.sv
cart_mapper.sv
cart_checker.sv
tb_cart_mapper.sv

// File: cart_mapper.sv
/* Cartridge mapper top: PRG and CHR bankers feeding
   the memory address composer */
`timescale 1ns/100ps

module cart_mapper (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cart_pkg::cart_flags_t flags,
	input  bus_pkg::cpu_bus_t     cpu,
	input  bus_pkg::ppu_bus_t     ppu,
	output bus_pkg::mem_req_t     req
);

	import cart_pkg::*;

	logic [PRG_PAGE_W-1:0] prg_page; // 16 KiB PRG page
	logic [CHR_PAGE_W-1:0] chr_page; // 8 KiB CHR page
	logic                  vram_a10; // Mirroring result

	prg_bank_regs prg_bank_regs0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.flags    (flags),
		.cpu      (cpu),
		.prg_page (prg_page)
	);

	chr_bank_regs chr_bank_regs0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.flags    (flags),
		.cpu      (cpu),
		.ppu      (ppu),
		.chr_page (chr_page),
		.vram_a10 (vram_a10)
	);

	mem_addr_composer mem_addr_composer0 (
		.flags    (flags),
		.cpu      (cpu),
		.ppu      (ppu),
		.prg_page (prg_page),
		.chr_page (chr_page),
		.vram_a10 (vram_a10),
		.req      (req)
	);

endmodule

// File: cart_pkg.sv
/* Cartridge configuration: flag word layout, mapper kinds,
   mapper number decode and bank page widths */
package cart_pkg;

	// Page widths in the 22-bit memory map
	localparam int PRG_PAGE_W = 8; // 16 KiB PRG pages
	localparam int CHR_PAGE_W = 9; // 8 KiB CHR pages

	// Camerica upper window always shows this page
	localparam logic [PRG_PAGE_W-1:0] PRG_FIXED_LAST = 8'd15;

	// Cart flags word, bit positions as loaded by the cart loader
	typedef struct packed {
		logic [15:0] rsvd_hi;      // Bits 31:16, submapper etc
		logic        chr_ram;      // Bit 15, CHR is writable RAM
		logic        vertical_mirror; // Bit 14
		logic [5:0]  rsvd_lo;      // Bits 13:8, ROM size info
		logic [7:0]  mapper_num;   // iNES mapper number
	} cart_flags_t;

	// Discrete mappers handled here
	typedef enum logic [1:0] {
		kind_nrom,         // Mapper 0
		kind_color_dreams, // Mapper 11
		kind_gxrom,        // Mapper 66
		kind_camerica      // Mapper 71
	} mapper_kind_e;

	// Unknown numbers fall back to fixed banks
	function automatic mapper_kind_e mapper_kind_of(input logic [7:0] num);
		mapper_kind_e kind;
		case (num)
			8'd11:   kind = kind_color_dreams;
			8'd66:   kind = kind_gxrom;
			8'd71:   kind = kind_camerica;
			default: kind = kind_nrom;
		endcase
		return kind;
	endfunction

endpackage

// File: chr_bank_regs.sv
/* CHR bank register, Fire Hawk single-screen select
   and VRAM A10 mirroring decision */
`timescale 1ns/100ps

module chr_bank_regs (
	input  logic                          clk,
	input  logic                          rst_n,
	input  cart_pkg::cart_flags_t         flags,
	input  bus_pkg::cpu_bus_t             cpu,
	input  bus_pkg::ppu_bus_t             ppu,
	output logic [cart_pkg::CHR_PAGE_W-1:0] chr_page,
	output logic                          vram_a10
);

	import cart_pkg::*;

	mapper_kind_e kind;     // Decoded mapper kind
	logic         reg_wr;   // Write strobe into $8000-$FFFF
	logic         nt_wr;    // Write into $8000-$9FFF
	logic [3:0]   chr_bank; // Selected 8 KiB CHR bank
	logic         nt_sel;   // Camerica one-screen nametable

	assign kind   = mapper_kind_of(flags.mapper_num);
	assign reg_wr = cpu.ce && cpu.write && cpu.addr[15];
	assign nt_wr  = reg_wr && (cpu.addr[14:13] == 2'b00);

	// CHR bank register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			chr_bank <= '0;
		end else if (reg_wr) begin
			case (kind)
				kind_color_dreams: begin
					chr_bank <= cpu.data[7:4]; // Upper nibble
				end
				kind_gxrom: begin
					chr_bank <= {2'b00, cpu.data[1:0]}; // D1:0
				end
				default: begin
					chr_bank <= chr_bank; // Fixed CHR page 0
				end
			endcase
		end
	end

	// Fire Hawk nametable select, Camerica only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			nt_sel <= 1'b0;
		end else if (nt_wr && (kind == kind_camerica)) begin
			nt_sel <= cpu.data[4];
		end
	end

	assign chr_page = {{(CHR_PAGE_W-4){1'b0}}, chr_bank}; // Zero-extended bank

	// Mirroring
	always_comb begin
		if (flags.vertical_mirror) begin
			vram_a10 = ppu.addr[10]; // Vertical
		end else if (kind == kind_camerica) begin
			// Fire Hawk carts ship with the flag clear
			vram_a10 = nt_sel;
		end else begin
			vram_a10 = ppu.addr[11]; // Horizontal
		end
	end

endmodule

// File: mem_addr_composer.sv
/* Combines PRG and CHR page numbers with bus offsets
   into the memory request with access permissions */
`timescale 1ns/100ps

module mem_addr_composer (
	input  cart_pkg::cart_flags_t         flags,
	input  bus_pkg::cpu_bus_t             cpu,
	input  bus_pkg::ppu_bus_t             ppu,
	input  logic [cart_pkg::PRG_PAGE_W-1:0] prg_page,
	input  logic [cart_pkg::CHR_PAGE_W-1:0] chr_page,
	input  logic                          vram_a10,
	output bus_pkg::mem_req_t             req
);

	import bus_pkg::*;

	logic [MEM_ADDR_W-1:0] prg_offs; // Page and CPU offset
	logic [MEM_ADDR_W-1:0] chr_offs; // Page and PPU offset

	assign prg_offs = {prg_page, cpu.addr[13:0]}; // 16 KiB granularity
	assign chr_offs = {chr_page, ppu.addr[12:0]}; // 8 KiB granularity

	always_comb begin
		req.prg_addr  = PRG_ROM_BASE | prg_offs;
		req.chr_addr  = CHR_ROM_BASE | chr_offs; // Base sits above any page
		// ROM reads only, writes hit the mapper registers
		req.prg_allow = cpu.addr[15] && !cpu.write;
		req.chr_allow = flags.chr_ram; // Writable only when CHR is RAM
		req.vram_ce   = ppu.addr[13];  // Nametable space
		req.vram_a10  = vram_a10;
	end

endmodule

// File: prg_bank_regs.sv
/* PRG bank register and 16 KiB PRG page selection
   for NROM, Color Dreams, GxROM and Camerica */
`timescale 1ns/100ps

module prg_bank_regs (
	input  logic                          clk,
	input  logic                          rst_n,
	input  cart_pkg::cart_flags_t         flags,
	input  bus_pkg::cpu_bus_t             cpu,
	output logic [cart_pkg::PRG_PAGE_W-1:0] prg_page
);

	import cart_pkg::*;

	mapper_kind_e kind;     // Decoded mapper kind
	logic         reg_wr;   // Write strobe into $8000-$FFFF
	logic [3:0]   prg_bank; // Selected PRG bank

	assign kind   = mapper_kind_of(flags.mapper_num);
	assign reg_wr = cpu.ce && cpu.write && cpu.addr[15]; // Whole upper half decodes

	// Bank register, field position depends on the board
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prg_bank <= '0;
		end else if (reg_wr) begin
			case (kind)
				kind_color_dreams: begin
					prg_bank <= {2'b00, cpu.data[1:0]}; // D1:0
				end
				kind_gxrom: begin
					prg_bank <= {2'b00, cpu.data[5:4]}; // D5:4
				end
				kind_camerica: begin
					if (cpu.addr[14]) begin // Only $C000-$FFFF selects bank
						prg_bank <= cpu.data[3:0];
					end
				end
				default: begin
					prg_bank <= prg_bank; // NROM has no register
				end
			endcase
		end
	end

	// 16 KiB page for the current CPU address
	always_comb begin
		case (kind)
			kind_color_dreams, kind_gxrom: begin
				// 32 KiB bank, A14 picks the half
				prg_page = {{(PRG_PAGE_W-5){1'b0}}, prg_bank, cpu.addr[14]};
			end
			kind_camerica: begin
				if (cpu.addr[14]) begin
					prg_page = PRG_FIXED_LAST; // Fixed upper window
				end else begin
					prg_page = {{(PRG_PAGE_W-4){1'b0}}, prg_bank};
				end
			end
			default: begin
				prg_page = {{(PRG_PAGE_W-1){1'b0}}, cpu.addr[14]}; // Flat 32 KiB
			end
		endcase
	end

endmodule

// File: tb_cart_mapper.sv
/* Cart mapper testbench: clock, reset, LCG, stimulus table
   with expected pages, watchdog, checker and DUT */
`timescale 1ns/100ps

module tb_cart_mapper;

	import cart_pkg::*;
	import bus_pkg::*;

	localparam int CLK_PERIOD      = 100;
	localparam int RST_CYCLES      = 5;
	localparam int NUM_TESTS       = 21;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 8 + RST_CYCLES;

	// One row, fields in the same order as the table literals
	typedef struct packed {
		logic [7:0]  mapper;
		logic        vmir;      // Vertical mirror flag
		logic        chr_ram;
		logic        wr_en;     // Row has a register write
		logic        wr_ce;     // ce during that write
		logic [15:0] wr_addr;
		logic [7:0]  wr_data;
		logic [7:0]  wr_mask;   // Data bits the mapper uses, others random
		logic [1:0]  cpu_hi;    // Probe A15:A14
		logic        cpu_wr;    // Probe is a write cycle
		logic [3:0]  ppu_hi;    // Probe A13:A10
		logic [7:0]  exp_prg;   // Expected 16 KiB page
		logic [8:0]  exp_chr;   // Expected 8 KiB page
		logic        exp_a10;
		logic        exp_allow;
	} test_entry_t;

	logic        clk;
	logic        rst_n;
	cart_flags_t flags;
	cpu_bus_t    cpu;
	ppu_bus_t    ppu;
	mem_req_t    req;
	mem_req_t    exp_req;
	logic        check_en;
	int          test_idx;
	int          pass_cnt;
	int          fail_cnt;
	logic [31:0] rnd_state; // LCG state
	test_entry_t tbl [NUM_TESTS];

	cart_mapper dut0 (
		.clk   (clk),
		.rst_n (rst_n),
		.flags (flags),
		.cpu   (cpu),
		.ppu   (ppu),
		.req   (req)
	);

	cart_checker checker0 (
		.clk      (clk),
		.check_en (check_en),
		.test_idx (test_idx),
		.req      (req),
		.exp_req  (exp_req),
		.pass_cnt (pass_cnt),
		.fail_cnt (fail_cnt)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cart_flags_t flags_of(input test_entry_t e);
		cart_flags_t f;
		f                 = '0;
		f.mapper_num      = e.mapper;
		f.vertical_mirror = e.vmir;
		f.chr_ram         = e.chr_ram;
		return f;
	endfunction

	// Request built from the expected pages and the probe offsets
	function automatic mem_req_t expect_req(input test_entry_t e, input logic [15:0] ca,
		input logic [13:0] pa);
		mem_req_t r;
		r.prg_addr  = PRG_ROM_BASE | {e.exp_prg, ca[13:0]};
		r.prg_allow = e.exp_allow;
		r.chr_addr  = CHR_ROM_BASE | {e.exp_chr, pa[12:0]};
		r.chr_allow = e.chr_ram;
		r.vram_a10  = e.exp_a10;
		r.vram_ce   = pa[13];
		return r;
	endfunction

	// mapper, vmir chr_ram, wr_en wr_ce, wr_addr, wr_data, wr_mask,
	// cpu_hi cpu_wr, ppu_hi, exp_prg, exp_chr, exp_a10 exp_allow
	task automatic fill_table();
		tbl[0]  = {8'd0, 2'b10, 2'b00, 16'h0000, 8'h00, 8'h00, 3'b100, 4'h0, 8'd0, 9'd0, 2'b01};
		tbl[1]  = {8'd0, 2'b10, 2'b00, 16'h0000, 8'h00, 8'h00, 3'b110, 4'h5, 8'd1, 9'd0, 2'b11};
		tbl[2]  = {8'd0, 2'b10, 2'b11, 16'h8000, 8'hff, 8'h00, 3'b010, 4'h8, 8'd1, 9'd0, 2'b00};
		tbl[3]  = {8'd0, 2'b10, 2'b00, 16'h0000, 8'h00, 8'h00, 3'b111, 4'h1, 8'd1, 9'd0, 2'b10};
		tbl[4]  = {8'd11, 2'b01, 2'b00, 16'h0000, 8'h00, 8'h00, 3'b100, 4'h2, 8'd0, 9'd0, 2'b11};
		tbl[5]  = {8'd11, 2'b01, 2'b11, 16'h8000, 8'h52, 8'hf3, 3'b110, 4'h1, 8'd5, 9'd5, 2'b01};
		tbl[6]  = {8'd11, 2'b01, 2'b10, 16'hffff, 8'h31, 8'h00, 3'b100, 4'h6, 8'd4, 9'd5, 2'b11};
		tbl[7]  = {8'd11, 2'b01, 2'b11, 16'hc123, 8'ha3, 8'hf3, 3'b100, 4'h0, 8'd6, 9'd10, 2'b01};
		tbl[8]  = {8'd66, 2'b10, 2'b00, 16'h0000, 8'h00, 8'h00, 3'b110, 4'h1, 8'd1, 9'd0, 2'b11};
		tbl[9]  = {8'd66, 2'b10, 2'b11, 16'h8000, 8'h32, 8'h33, 3'b100, 4'h2, 8'd6, 9'd2, 2'b01};
		tbl[10] = {8'd66, 2'b10, 2'b11, 16'he000, 8'h11, 8'h33, 3'b110, 4'hd, 8'd3, 9'd1, 2'b11};
		tbl[11] = {8'd71, 2'b00, 2'b00, 16'h0000, 8'h00, 8'h00, 3'b100, 4'h2, 8'd0, 9'd0, 2'b01};
		tbl[12] = {8'd71, 2'b00, 2'b11, 16'hc000, 8'h07, 8'h0f, 3'b100, 4'h0, 8'd7, 9'd0, 2'b01};
		tbl[13] = {8'd71, 2'b00, 2'b00, 16'h0000, 8'h00, 8'h00, 3'b110, 4'h0, 8'd15, 9'd0, 2'b01};
		tbl[14] = {8'd71, 2'b00, 2'b11, 16'ha000, 8'h00, 8'h00, 3'b100, 4'h0, 8'd7, 9'd0, 2'b01};
		tbl[15] = {8'd71, 2'b00, 2'b11, 16'h8000, 8'h10, 8'h10, 3'b100, 4'h0, 8'd7, 9'd0, 2'b11};
		tbl[16] = {8'd71, 2'b00, 2'b10, 16'h9fff, 8'h00, 8'h10, 3'b110, 4'h2, 8'd15, 9'd0, 2'b11};
		tbl[17] = {8'd71, 2'b00, 2'b11, 16'hffff, 8'h0a, 8'h0f, 3'b101, 4'h0, 8'd10, 9'd0, 2'b10};
		tbl[18] = {8'd71, 2'b11, 2'b00, 16'h0000, 8'h00, 8'h00, 3'b110, 4'h1, 8'd15, 9'd0, 2'b11};
		tbl[19] = {8'd71, 2'b11, 2'b11, 16'h8000, 8'h10, 8'h10, 3'b100, 4'h2, 8'd0, 9'd0, 2'b01};
		tbl[20] = {8'd4, 2'b00, 2'b11, 16'h8000, 8'h00, 8'h00, 3'b110, 4'h2, 8'd1, 9'd0, 2'b11};
	endtask

	// Flags only change while reset is low
	task automatic reset_with_flags(input cart_flags_t f);
		@(posedge clk);
		rst_n <= 1'b0;
		flags <= f;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic run_entry(input int idx);
		test_entry_t e;
		logic [7:0]  wdata;
		logic [15:0] caddr;
		logic [13:0] paddr;
		e         = tbl[idx];
		rnd_state = lcg_step(rnd_state);
		wdata     = (e.wr_data & e.wr_mask) | (rnd_state[23:16] & ~e.wr_mask);
		rnd_state = lcg_step(rnd_state);
		caddr     = {e.cpu_hi, rnd_state[29:16]}; // Random offset below A14
		rnd_state = lcg_step(rnd_state);
		paddr     = {e.ppu_hi, rnd_state[25:16]}; // Random offset below A10
		@(posedge clk); // Write strobe cycle
		cpu.addr  <= e.wr_addr;
		cpu.data  <= wdata;
		cpu.write <= e.wr_en;
		cpu.ce    <= e.wr_en & e.wr_ce;
		@(posedge clk); // Probe cycle
		cpu.addr  <= caddr;
		cpu.data  <= rnd_state[31:24];
		cpu.write <= e.cpu_wr;
		cpu.ce    <= 1'b0; // Probe only, no register strobe
		ppu.addr  <= paddr;
		exp_req   <= expect_req(e, caddr, paddr);
		test_idx  <= idx;
		check_en  <= 1'b1;
		@(posedge clk);
		check_en  <= 1'b0;
		cpu.write <= 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		cart_flags_t next_flags;
		fill_table();
		rnd_state = 32'h87e7;
		rst_n     = 1'b0;
		flags     = flags_of(tbl[0]);
		cpu       = '0;
		ppu       = '0;
		exp_req   = '0;
		check_en  = 1'b0;
		test_idx  = 0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < NUM_TESTS; i++) begin
			next_flags = flags_of(tbl[i]);
			if (next_flags != flags) begin
				reset_with_flags(next_flags); // New cart, fresh registers
			end
			run_entry(i);
		end
		@(posedge clk);
		$display("Summary: %0d of %0d tests passed, %0d failed", pass_cnt, NUM_TESTS, fail_cnt);
		if (fail_cnt == 0 && pass_cnt == NUM_TESTS) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the test table did not finish within %0d clock cycles",
			WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule
